/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fifo_capture
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* vlog.f */
+incdir+logic
+incdir+bench
logic/capture_pkg.sv
logic/sample_fifo.sv
logic/capture_ctrl.sv
logic/sample_packer.sv
logic/byte_reader.sv
logic/fifo_capture_top.sv
bench/tb_fifo_capture.sv

/* bench/capture_model.svh */
`ifndef CAPTURE_MODEL_SVH
`define CAPTURE_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h4c3c_4cc6;

logic [`SAMPLE_W-1:0] exp_q[$];     // expected samples in capture order
logic [`SAMPLE_W-1:0] got_q[$];     // decoded from the byte stream
logic [7:0]           byte_q[$];    // bytes as read

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// run of n kept samples, step apart, wraps at the sample width
function automatic void expect_run(input logic [`SAMPLE_W-1:0] first, input int step,
                                   input int n);
    logic [`SAMPLE_W-1:0] s;
    s = first;
    for (int i = 0; i < n; i++) begin
        exp_q.push_back(s);
        s = s + `SAMPLE_W'(step);
    end
endfunction

// nine bytes carry six samples, msb first
function automatic void decode_hires();
    logic [71:0] bits;
    bits = '0;
    got_q.delete();
    for (int g = 0; g + 9 <= byte_q.size(); g += 9) begin
        for (int k = 0; k < 9; k++) begin
            bits = {bits[63:0], byte_q[g + k]};
        end
        for (int k = 0; k < 6; k++) begin
            got_q.push_back(bits[71 - 12 * k -: 12]);
        end
    end
endfunction

// one byte per sample in low resolution
function automatic logic [7:0] low_res_byte(input logic [`SAMPLE_W-1:0] s, input logic lsb);
    return lsb ? s[7:0] : s[11:4];
endfunction

`endif

/* bench/tb_fifo_capture.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module tb_fifo_capture;
    localparam int CLK_PERIOD = 100;

    logic                 adc_sampleclk;
    logic                 reset;
    logic [`SAMPLE_W-1:0] adc_datain_i = '0;
    logic                 arm_i;
    logic                 adc_capture_go_i;
    logic                 adc_segment_go_i;
    logic [`SEG_W-1:0]    num_segments_i;
    logic [`CNT_W-1:0]    presample_i;
    logic [`CNT_W-1:0]    max_samples_i;
    logic [`DS_W-1:0]     downsample_i;
    logic                 low_res_i;
    logic                 low_res_lsb_i;
    logic                 fifo_read_fifoen_i;
    logic                 adc_capture_stop_o;
    logic                 fifo_read_fifoempty_o;
    logic [7:0]           fifo_read_data_o;
    logic                 error_flag_o;
    logic [4:0]           error_stat_o;

    logic [`SAMPLE_W-1:0] data_start;
    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests_run = 0;
    int bad_tests = 0;
    int budget_cycles = 0;
    int max1;
    int max2;
    int p2;
    int max3;
    int d3;
    int max4;
    logic lsb3;

    `include "capture_model.svh"

    fifo_capture_top DUT (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;
    end

    // running sample counter, reloaded while in reset
    always @(negedge adc_sampleclk) begin
        if (reset) begin
            adc_datain_i <= data_start;
        end else begin
            adc_datain_i <= adc_datain_i + `SAMPLE_W'(1);
        end
    end

    task automatic check_value(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("** Error: %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_errors = 0;
        exp_q.delete();
        got_q.delete();
        byte_q.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            bad_tests++;
        end
    endtask

    // settings go in before the arm edge
    task automatic arm_capture(input int pre, input int max, input int ds, input int segs,
                               input logic lres, input logic lsb);
        @(negedge adc_sampleclk);
        presample_i    = `CNT_W'(pre);
        max_samples_i  = `CNT_W'(max);
        downsample_i   = `DS_W'(ds);
        num_segments_i = `SEG_W'(segs);
        low_res_i      = lres;
        low_res_lsb_i  = lsb;
        arm_i          = 1'b0;
        @(negedge adc_sampleclk);
        arm_i = 1'b1;
        repeat (4) @(negedge adc_sampleclk);    // flush, then armed
    endtask

    // first kept sample is presented the cycle after the FSM samples go
    task automatic pulse_go(input logic segment, output logic [`SAMPLE_W-1:0] first);
        @(negedge adc_sampleclk);
        if (segment) begin
            adc_segment_go_i = 1'b1;
        end else begin
            adc_capture_go_i = 1'b1;
        end
        @(posedge adc_sampleclk);
        first = adc_datain_i + `SAMPLE_W'(1);
        @(negedge adc_sampleclk);
        adc_capture_go_i = 1'b0;
        adc_segment_go_i = 1'b0;
    endtask

    // reads only while data is available, until byte_q holds n bytes
    task automatic read_bytes(input int n, input int limit);
        int waited;
        waited = 0;
        while (byte_q.size() < n && waited < limit) begin
            @(negedge adc_sampleclk);
            fifo_read_fifoen_i = !fifo_read_fifoempty_o;
            if (!fifo_read_fifoempty_o) begin
                byte_q.push_back(fifo_read_data_o);
            end
            waited++;
        end
        @(negedge adc_sampleclk);
        fifo_read_fifoen_i = 1'b0;
        if (byte_q.size() < n) begin
            $display("timed out after %0d cycles with %0d of %0d bytes read",
                     limit, byte_q.size(), n);
            test_errors++;
        end
    endtask

    task automatic compare_samples();
        check_value(got_q.size(), exp_q.size(), "decoded sample count");
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_value(int'(got_q[i]), int'(exp_q[i]), $sformatf("sample %0d", i));
        end
    endtask

    task automatic run_no_presample();
        logic [`SAMPLE_W-1:0] first;
        start_test();
        arm_capture(0, max1, 0, 1, 1'b0, 1'b0);
        pulse_go(1'b0, first);
        expect_run(first, 1, max1);
        read_bytes(max1 * 3 / 2, 3 * max1 + 40);
        decode_hires();
        compare_samples();
        check_value(int'(adc_capture_stop_o), 1, "capture stop after the capture");
        finish_test("no presample, high resolution");
    endtask

    task automatic run_presample();
        logic [`SAMPLE_W-1:0] first;
        start_test();
        arm_capture(p2, max2, 0, 1, 1'b0, 1'b0);
        repeat (p2 + 4) @(negedge adc_sampleclk);   // one presample per cycle
        pulse_go(1'b0, first);
        expect_run(first - `SAMPLE_W'(p2), 1, max2);
        read_bytes(max2 * 3 / 2, 3 * max2 + 40);
        decode_hires();
        compare_samples();
        check_value(int'(error_flag_o), 0, "error flag");
        finish_test("presample");
    endtask

    task automatic run_downsample();
        logic [`SAMPLE_W-1:0] first;
        int best;
        int best_hits;
        int hits;
        start_test();
        arm_capture(0, max3, d3, 1, 1'b1, lsb3);
        pulse_go(1'b0, first);
        read_bytes(max3, 3 * max3 * (d3 + 1) + 40);
        // the first kept sample lies at most d3 past the trigger value
        best = 0;
        best_hits = -1;
        for (int o = 0; o <= d3; o++) begin
            hits = 0;
            for (int i = 0; i < byte_q.size(); i++) begin
                if (byte_q[i] == low_res_byte(first + `SAMPLE_W'(o + i * (d3 + 1)), lsb3)) begin
                    hits++;
                end
            end
            if (hits > best_hits) begin
                best_hits = hits;
                best = o;
            end
        end
        expect_run(first + `SAMPLE_W'(best), d3 + 1, max3);
        check_value(byte_q.size(), max3, "low resolution byte count");
        for (int i = 0; i < byte_q.size() && i < exp_q.size(); i++) begin
            check_value(int'(byte_q[i]), int'(low_res_byte(exp_q[i], lsb3)),
                        $sformatf("byte %0d", i));
        end
        finish_test("downsample, low resolution");
    endtask

    task automatic run_segments();
        logic [`SAMPLE_W-1:0] first;
        start_test();
        arm_capture(0, max4, 0, 2, 1'b0, 1'b0);
        pulse_go(1'b0, first);
        expect_run(first, 1, max4);
        read_bytes(max4 * 3 / 2, 3 * max4 + 40);    // first segment fully drained
        check_value(int'(adc_capture_stop_o), 0, "capture stop between segments");
        pulse_go(1'b1, first);
        expect_run(first, 1, max4);
        read_bytes(max4 * 3, 3 * max4 + 40);
        decode_hires();
        compare_samples();
        check_value(int'(adc_capture_stop_o), 1, "capture stop after two segments");
        finish_test("two segments");
    endtask

    task automatic run_errors();
        logic [`SAMPLE_W-1:0] first;
        start_test();
        arm_capture(20, 48, 0, 1, 1'b0, 1'b0);
        pulse_go(1'b0, first);  // presamples still filling
        check_value(int'(error_stat_o), 'h10, "error status after an early trigger");
        check_value(int'(error_flag_o), 1, "error flag after an early trigger");
        arm_capture(0, 24, 0, 1, 1'b0, 1'b0);
        check_value(int'(error_stat_o), 0, "error status after re-arming");
        check_value(int'(error_flag_o), 0, "error flag after re-arming");
        check_value(int'(fifo_read_fifoempty_o), 1, "empty flag before the capture");
        fifo_read_fifoen_i = 1'b1;
        repeat (4) @(negedge adc_sampleclk);    // fourth byte pops the missing word
        fifo_read_fifoen_i = 1'b0;
        @(negedge adc_sampleclk);   // pulse, then latched
        check_value(int'(error_stat_o), 'h01, "error status after an empty read");
        check_value(int'(error_flag_o), 1, "error flag after an empty read");
        pulse_go(1'b0, first);
        read_bytes(12, 200);
        for (int i = 0; i < byte_q.size(); i++) begin
            check_value(int'(byte_q[i]), 0, $sformatf("byte %0d after underflow", i));
        end
        arm_capture(0, 24, 0, 1, 1'b0, 1'b0);
        check_value(int'(error_stat_o), 0, "error status after the second re-arm");
        check_value(int'(error_flag_o), 0, "error flag after the second re-arm");
        finish_test("errors");
    endtask

    initial begin
        wait (budget_cycles > 0);
        repeat (2 * budget_cycles) @(posedge adc_sampleclk);
        $display("watchdog expired after %0d cycles, the run did not finish", 2 * budget_cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        reset              = 1'b1;
        arm_i              = 1'b0;
        adc_capture_go_i   = 1'b0;
        adc_segment_go_i   = 1'b0;
        num_segments_i     = `SEG_W'(1);
        presample_i        = '0;
        max_samples_i      = `CNT_W'(3);
        downsample_i       = '0;
        low_res_i          = 1'b0;
        low_res_lsb_i      = 1'b0;
        fifo_read_fifoen_i = 1'b0;
        data_start = `SAMPLE_W'(rand_bits(`SAMPLE_W));
        max1 = 6 * (6 + int'(rand_bits(4)));    // multiples of six keep word pairs whole
        max2 = 6 * (6 + int'(rand_bits(4)));
        p2   = 1 + int'(rand_bits(5));
        max3 = 3 * (8 + int'(rand_bits(4)));
        d3   = 1 + int'(rand_bits(3));
        lsb3 = (rand_bits(1) != 32'd0);
        max4 = 6 * (4 + int'(rand_bits(3)));
        budget_cycles = 40 + (3 * max1 + 50) + (3 * max2 + p2 + 60)
                      + (3 * max3 * (d3 + 1) + 50) + (6 * max4 + 100) + 500;
        repeat (8) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk);
        reset = 1'b0;
        run_no_presample();
        run_presample();
        run_downsample();
        run_segments();
        run_errors();
        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, bad_tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* logic/fifo_capture_top.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module fifo_capture_top
    import capture_pkg::*;
(
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic [`SAMPLE_W-1:0] adc_datain_i,
    input  logic                 arm_i,
    input  logic                 adc_capture_go_i,
    input  logic                 adc_segment_go_i,
    input  logic [`SEG_W-1:0]    num_segments_i,
    input  logic [`CNT_W-1:0]    presample_i,
    input  logic [`CNT_W-1:0]    max_samples_i,
    input  logic [`DS_W-1:0]     downsample_i,
    input  logic                 low_res_i,
    input  logic                 low_res_lsb_i,
    input  logic                 fifo_read_fifoen_i,
    output logic                 adc_capture_stop_o,
    output logic                 fifo_read_fifoempty_o,
    output logic [7:0]           fifo_read_data_o,
    output logic                 error_flag_o,
    output logic [4:0]           error_stat_o
);
    capture_state_t       state;
    fifo_flags_t          fast_flags;
    fifo_flags_t          slow_flags;
    logic                 fast_wr;
    logic                 fast_rd;
    logic                 presamp_drain;
    logic                 pack_fast_rd;
    logic [`SAMPLE_W-1:0] fast_dout;
    logic                 drain_en;
    logic                 flush;
    logic                 presamp_error;
    logic                 slow_wr;
    logic                 slow_rd;
    slow_word_u           slow_din;
    slow_word_u           slow_dout;
    capture_err_t         err_now;
    capture_err_t         err_q;
    logic                 unf_sticky;

    capture_ctrl u_ctrl (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .capture_go_i    (adc_capture_go_i),
        .segment_go_i    (adc_segment_go_i),
        .num_segments_i  (num_segments_i),
        .presample_i     (presample_i),
        .max_samples_i   (max_samples_i),
        .downsample_i    (downsample_i),
        .fast_flags_i    (fast_flags),
        .fast_wr_o       (fast_wr),
        .presamp_drain_o (presamp_drain),
        .drain_en_o      (drain_en),
        .flush_o         (flush),
        .presamp_error_o (presamp_error),
        .capture_stop_o  (adc_capture_stop_o),
        .state_o         (state)
    );

    assign fast_rd = presamp_drain || pack_fast_rd;  // discard or pack

    sample_fifo #(.WIDTH(`SAMPLE_W), .DEPTH(`FAST_DEPTH)) u_fast_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .wr_i          (fast_wr),
        .din_i         (adc_datain_i),
        .rd_i          (fast_rd),
        .dout_o        (fast_dout),
        .flags_o       (fast_flags)
    );

    sample_packer u_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .drain_en_i    (drain_en),
        .state_i       (state),
        .fast_dout_i   (fast_dout),
        .fast_flags_i  (fast_flags),
        .slow_flags_i  (slow_flags),
        .fast_rd_o     (pack_fast_rd),
        .slow_wr_o     (slow_wr),
        .slow_din_o    (slow_din)
    );

    sample_fifo #(.WIDTH(`WORD_W), .DEPTH(`SLOW_DEPTH)) u_slow_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (flush),
        .wr_i          (slow_wr),
        .din_i         (slow_din),
        .rd_i          (slow_rd),
        .dout_o        (slow_dout),
        .flags_o       (slow_flags)
    );

    byte_reader u_reader (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .flush_i            (flush),
        .read_en_i          (fifo_read_fifoen_i),
        .low_res_i          (low_res_i),
        .low_res_lsb_i      (low_res_lsb_i),
        .slow_dout_i        (slow_dout),
        .underflow_sticky_i (unf_sticky),
        .slow_rd_o          (slow_rd),
        .data_o             (fifo_read_data_o)
    );

    assign fifo_read_fifoempty_o = slow_flags.empty;

    assign err_now = '{presamp:  presamp_error,
                       fast_ovf: fast_flags.overflow,
                       fast_unf: fast_flags.underflow,
                       slow_ovf: slow_flags.overflow,
                       slow_unf: slow_flags.underflow};

    // sticky status, cleared only by re-arming
    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush) begin
            err_q        <= '0;
            error_flag_o <= 1'b0;
            unf_sticky   <= 1'b0;
        end else begin
            if (err_now != '0) begin
                err_q        <= err_q | err_now;
                error_flag_o <= 1'b1;
            end
            if (slow_flags.underflow) begin
                unf_sticky <= 1'b1;
            end
        end
    end

    assign error_stat_o = err_q;

endmodule

/* logic/byte_reader.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module byte_reader
    import capture_pkg::*;
(
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  logic       flush_i,
    input  logic       read_en_i,
    input  logic       low_res_i,
    input  logic       low_res_lsb_i,
    input  slow_word_u slow_dout_i,
    input  logic       underflow_sticky_i,
    output logic       slow_rd_o,
    output logic [7:0] data_o
);
    logic [3:0]           phase;    // byte within the word group
    logic [3:0]           tail_q;
    logic [`SAMPLE_W-1:0] lr_sample;

    assign slow_rd_o = read_en_i && (low_res_i ? (phase == 4'd2)
                                               : (phase == 4'd3 || phase == 4'd8));
    assign lr_sample = slow_dout_i.samples[2'd2 - phase[1:0]];

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            phase <= '0;
        end else if (read_en_i) begin
            if (low_res_i) begin
                phase <= (phase >= 4'd2) ? 4'd0 : phase + 4'd1;
            end else begin
                phase <= (phase >= 4'd8) ? 4'd0 : phase + 4'd1;
            end
        end
    end

    // nibble that opens byte 4, the rest comes from the next word
    always_ff @(posedge adc_sampleclk) begin
        if (read_en_i && !low_res_i && phase == 4'd3) begin
            tail_q <= slow_dout_i.bytes.tail;
        end
    end

    always_comb begin
        data_o = 8'h00;
        if (underflow_sticky_i) begin
            data_o = 8'h00;     // stays zero until re-armed
        end else if (low_res_i) begin
            data_o = low_res_lsb_i ? lr_sample[7:0] : lr_sample[`SAMPLE_W-1 -: 8];
        end else begin
            case (phase)
                4'd0:    data_o = slow_dout_i.bytes.b[3];
                4'd1:    data_o = slow_dout_i.bytes.b[2];
                4'd2:    data_o = slow_dout_i.bytes.b[1];
                4'd3:    data_o = slow_dout_i.bytes.b[0];
                4'd4:    data_o = {tail_q, slow_dout_i.bytes.b[3][7:4]};
                4'd5:    data_o = slow_dout_i[31:24];   // second word is nibble shifted
                4'd6:    data_o = slow_dout_i[23:16];
                4'd7:    data_o = slow_dout_i[15:8];
                4'd8:    data_o = slow_dout_i[7:0];
                default: data_o = 8'h00;
            endcase
        end
    end

endmodule

/* logic/sample_packer.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module sample_packer
    import capture_pkg::*;
(
    input  logic                 adc_sampleclk,
    input  logic                 reset,
    input  logic                 flush_i,
    input  logic                 drain_en_i,
    input  capture_state_t       state_i,
    input  logic [`SAMPLE_W-1:0] fast_dout_i,
    input  fifo_flags_t          fast_flags_i,
    input  fifo_flags_t          slow_flags_i,
    output logic                 fast_rd_o,
    output logic                 slow_wr_o,
    output slow_word_u           slow_din_o
);
    logic [1:0] rd_cnt;     // reads into the current word
    slow_word_u word_q;

    // stall on a full slow fifo, the fast fifo takes up the slack
    assign fast_rd_o  = drain_en_i && !fast_flags_i.empty && !slow_flags_i.full;
    assign slow_din_o = word_q;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i || state_i == IDLE) begin
            rd_cnt    <= '0;  // a partial word left from the last capture is dropped
            slow_wr_o <= 1'b0;
        end else begin
            slow_wr_o <= fast_rd_o && (rd_cnt == 2'd2);
            if (fast_rd_o) begin
                rd_cnt <= (rd_cnt == 2'd2) ? 2'd0 : rd_cnt + 2'd1;
            end
        end
    end

    // oldest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (fast_rd_o) begin
            word_q.samples <= {word_q.samples[1:0], fast_dout_i};
        end
    end

    // write lands a cycle after the third read, only the reader changes the fill meanwhile
    a_no_wr_full: assert property (@(posedge adc_sampleclk) disable iff (reset)
        slow_wr_o |-> !slow_flags_i.full);

endmodule

/* logic/capture_ctrl.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_ctrl
    import capture_pkg::*;
(
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  logic              arm_i,
    input  logic              capture_go_i,
    input  logic              segment_go_i,
    input  logic [`SEG_W-1:0] num_segments_i,
    input  logic [`CNT_W-1:0] presample_i,
    input  logic [`CNT_W-1:0] max_samples_i,
    input  logic [`DS_W-1:0]  downsample_i,
    input  fifo_flags_t       fast_flags_i,
    output logic              fast_wr_o,
    output logic              presamp_drain_o,
    output logic              drain_en_o,
    output logic              flush_o,
    output logic              presamp_error_o,
    output logic              capture_stop_o,
    output capture_state_t    state_o
);
    capture_state_t    state;
    logic              arm_r;
    logic              arm_r2;
    logic              armed;
    logic              segment_go_r;
    logic [`DS_W-1:0]  ds_cnt;
    logic              ds_wr_en;
    logic [`CNT_W-1:0] pre_cnt;
    logic [`CNT_W-1:0] sample_cnt;
    logic [`SEG_W-1:0] seg_cnt;
    logic              fsm_wr_en;
    logic              presamp_done;
    logic              last_sample;
    logic              last_segment;

    // arm edge gives a one cycle flush, armed follows it
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            arm_r2       <= 1'b0;
            flush_o      <= 1'b0;
            armed        <= 1'b0;
            segment_go_r <= 1'b0;
        end else begin
            arm_r        <= arm_i;
            arm_r2       <= arm_r;
            flush_o      <= arm_r && !arm_r2;
            segment_go_r <= segment_go_i;
            if (flush_o) begin
                armed <= 1'b1;
            end else if (capture_stop_o) begin
                armed <= 1'b0;
            end
        end
    end

    // keep one sample of every downsample_i+1, free running from the flush
    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_o) begin
            ds_cnt   <= '0;
            ds_wr_en <= 1'b0;
        end else if (ds_cnt == downsample_i) begin
            ds_cnt   <= '0;
            ds_wr_en <= 1'b1;
        end else begin
            ds_cnt   <= ds_cnt + `DS_W'(1);
            ds_wr_en <= 1'b0;
        end
    end

    assign fsm_wr_en       = state inside {PRESAMP_FILLING, PRESAMP_FULL, TRIGGERED};
    assign fast_wr_o       = ds_wr_en && fsm_wr_en && !flush_o;
    assign presamp_drain_o = fast_wr_o && (state == PRESAMP_FULL);  // one out per one in
    assign presamp_done    = (seg_cnt == '0) ? capture_go_i : segment_go_i;
    assign presamp_error_o = presamp_done && (state == PRESAMP_FILLING);
    assign last_sample     = fast_wr_o && (sample_cnt == max_samples_i - `CNT_W'(1));
    assign last_segment    = (seg_cnt == num_segments_i - `SEG_W'(1));
    assign state_o         = state;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_o) begin
            state          <= IDLE;
            pre_cnt        <= '0;
            sample_cnt     <= '0;
            seg_cnt        <= '0;
            drain_en_o     <= 1'b0;
            capture_stop_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pre_cnt    <= '0;
                    sample_cnt <= '0;
                    seg_cnt    <= '0;
                    if (armed && presample_i != '0) begin
                        state <= PRESAMP_FILLING;
                    end else if (armed && capture_go_i) begin
                        drain_en_o <= 1'b1;
                        state      <= TRIGGERED;
                    end
                end
                PRESAMP_FILLING: begin
                    if (presamp_done) begin    // early trigger, flagged by presamp_error_o
                        sample_cnt <= pre_cnt + `CNT_W'(fast_wr_o);
                        drain_en_o <= 1'b1;
                        state      <= TRIGGERED;
                    end else if (fast_wr_o) begin
                        pre_cnt <= pre_cnt + `CNT_W'(1);
                        if (pre_cnt == presample_i - `CNT_W'(1)) begin
                            state <= PRESAMP_FULL;
                        end
                    end
                end
                PRESAMP_FULL: begin
                    if (presamp_done) begin
                        sample_cnt <= presample_i;  // presamples count toward the segment
                        drain_en_o <= 1'b1;
                        state      <= TRIGGERED;
                    end
                end
                TRIGGERED: begin
                    if (fast_wr_o) begin
                        sample_cnt <= sample_cnt + `CNT_W'(1);
                    end
                    if (last_sample && last_segment) begin
                        capture_stop_o <= 1'b1;
                        state          <= DONE;
                    end else if (last_sample) begin
                        state <= SEGMENT_DONE;
                    end
                end
                SEGMENT_DONE: begin
                    // next segment only once the fast fifo is drained
                    if (fast_flags_i.empty) begin
                        drain_en_o <= 1'b0;
                        if (presample_i != '0) begin
                            seg_cnt    <= seg_cnt + `SEG_W'(1);
                            sample_cnt <= '0;
                            pre_cnt    <= '0;
                            state      <= PRESAMP_FILLING;
                        end else if (segment_go_i && !segment_go_r) begin
                            seg_cnt    <= seg_cnt + `SEG_W'(1);
                            sample_cnt <= '0;
                            drain_en_o <= 1'b1;
                            state      <= TRIGGERED;
                        end
                    end
                end
                DONE: begin
                    if (fast_flags_i.empty) begin
                        drain_en_o <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // a discard read always finds the presamples in the fifo
    a_drain_not_empty: assert property (@(posedge adc_sampleclk) disable iff (reset)
        presamp_drain_o |-> !fast_flags_i.empty);

endmodule

/* logic/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo
    import capture_pkg::*;
#(
    parameter int WIDTH = 12,
    parameter int DEPTH = 64
) (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  logic             flush_i,
    input  logic             wr_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    output fifo_flags_t      flags_o
);
    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             full;
    logic             empty;
    logic             do_wr;
    logic             do_rd;
    logic             overflow_q;
    logic             underflow_q;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_i && !full;   // write into a full buffer is dropped
    assign do_rd = rd_i && !empty;

    assign dout_o  = mem[rd_ptr];   // first word falls through
    assign flags_o = '{full: full, empty: empty, overflow: overflow_q, underflow: underflow_q};

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            overflow_q  <= 1'b0;
            underflow_q <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + (AW+1)'(1);
                2'b01:   count <= count - (AW+1)'(1);
                default: count <= count;
            endcase
            overflow_q  <= wr_i && full;    // one cycle pulse
            underflow_q <= rd_i && empty;
        end
    end

    a_count_bound: assert property (@(posedge adc_sampleclk) disable iff (reset)
        count <= (AW+1)'(DEPTH));

endmodule

/* logic/capture_pkg.sv */
`include "capture_params.svh"

package capture_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        SEGMENT_DONE,
        DONE
    } capture_state_t;

    // byte order of a slow word, as streamed in high resolution mode
    typedef struct packed {
        logic [3:0][7:0] b;     // b[3] is the top byte
        logic [3:0]      tail;  // low nibble of the last sample
    } byte_view_t;

    // one slow fifo word, three samples or four bytes plus a nibble
    typedef union packed {
        logic [2:0][`SAMPLE_W-1:0] samples;  // samples[2] is the oldest
        byte_view_t                bytes;
    } slow_word_u;

    typedef struct packed {
        logic full;
        logic empty;
        logic overflow;
        logic underflow;
    } fifo_flags_t;

    // same bit order as error_stat_o
    typedef struct packed {
        logic presamp;
        logic fast_ovf;
        logic fast_unf;
        logic slow_ovf;
        logic slow_unf;
    } capture_err_t;

endpackage

/* logic/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// adc sample and slow word widths
`define SAMPLE_W 12
`define WORD_W 36

// fifo sizes
`define FAST_DEPTH 64
`define SLOW_DEPTH 64

// counter widths
`define CNT_W 16  // sample and presample counters
`define SEG_W 8
`define DS_W 13

`endif
